/* hw/rv_decode_pkg.sv */
package rv_decode_pkg;

        localparam int XLEN       = 32;        // data path width.
        localparam int REG_ADDR_W = 5;         // register number width.

        // ******************************
        // base opcodes, inst[6:0]
        // ******************************
        localparam logic [6:0] OP_LUI    = 7'b0110111;
        localparam logic [6:0] OP_AUIPC  = 7'b0010111;
        localparam logic [6:0] OP_JAL    = 7'b1101111;
        localparam logic [6:0] OP_JALR   = 7'b1100111;
        localparam logic [6:0] OP_BRANCH = 7'b1100011;
        localparam logic [6:0] OP_LOAD   = 7'b0000011;
        localparam logic [6:0] OP_STORE  = 7'b0100011;
        localparam logic [6:0] OP_IMM    = 7'b0010011;
        localparam logic [6:0] OP_REG    = 7'b0110011;

        // ******************************
        // branch conditions, funct3
        // ******************************
        localparam logic [2:0] F3_BEQ  = 3'b000;
        localparam logic [2:0] F3_BNE  = 3'b001;
        localparam logic [2:0] F3_BLT  = 3'b100;  // signed.
        localparam logic [2:0] F3_BGE  = 3'b101;  // signed.
        localparam logic [2:0] F3_BLTU = 3'b110;
        localparam logic [2:0] F3_BGEU = 3'b111;

        // one instruction word, seen through each base format.
        // fields listed msb first.
        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } r_fmt;
                struct packed {
                        logic [11:0] imm_11_0;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i_fmt;
                struct packed {
                        logic [6:0] imm_11_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] imm_4_0;
                        logic [6:0] opcode;
                } s_fmt;
                struct packed {
                        logic       imm_12;
                        logic [5:0] imm_10_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [3:0] imm_4_1;
                        logic       imm_11;   // sits where rd[0] would be.
                        logic [6:0] opcode;
                } b_fmt;
                struct packed {
                        logic [19:0] imm_31_12;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } u_fmt;
                struct packed {
                        logic       imm_20;
                        logic [9:0] imm_10_1;
                        logic       imm_11;
                        logic [7:0] imm_19_12;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } j_fmt;
        } rv_inst_u;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
        input  rv_decode_pkg::rv_inst_u                i_inst,
        output logic [6:0]                             o_opcode,
        output logic [2:0]                             o_func_3,
        output logic [6:0]                             o_func_7,
        output logic [rv_decode_pkg::REG_ADDR_W-1:0]   o_rs1_num,
        output logic [rv_decode_pkg::REG_ADDR_W-1:0]   o_rs2_num,
        output logic [rv_decode_pkg::REG_ADDR_W-1:0]   o_rd_num,
        output logic [11:0]                            o_imm_12_i,
        output logic [11:0]                            o_imm_12_s,
        output logic [11:0]                            o_imm_12_b,
        output logic [19:0]                            o_imm_20_u,
        output logic [19:0]                            o_imm_20_j
);

        // fixed fields, same spot in every format.
        assign o_opcode  = i_inst.r_fmt.opcode;
        assign o_func_3  = i_inst.r_fmt.funct3;
        assign o_func_7  = i_inst.r_fmt.funct7;  // only meaningful for op.
        assign o_rs1_num = i_inst.r_fmt.rs1;
        assign o_rs2_num = i_inst.r_fmt.rs2;
        assign o_rd_num  = i_inst.r_fmt.rd;

        // ******************************
        // immediates, left unextended
        // ******************************
        assign o_imm_12_i = i_inst.i_fmt.imm_11_0;
        assign o_imm_12_s = {i_inst.s_fmt.imm_11_5, i_inst.s_fmt.imm_4_0};

        // b holds imm[12:1]; bit 0 is always zero.
        assign o_imm_12_b = {i_inst.b_fmt.imm_12,
                             i_inst.b_fmt.imm_11,
                             i_inst.b_fmt.imm_10_5,
                             i_inst.b_fmt.imm_4_1};

        assign o_imm_20_u = i_inst.u_fmt.imm_31_12;   // upper 20, as is.

        // j holds imm[20:1], unscrambled.
        assign o_imm_20_j = {i_inst.j_fmt.imm_20,
                             i_inst.j_fmt.imm_19_12,
                             i_inst.j_fmt.imm_11,
                             i_inst.j_fmt.imm_10_1};

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps

module register_file (
        input  logic                                   i_clk,
        input  logic                                   i_rst,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_rs1_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_rs2_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_w_reg_num,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_w_val,
        input  logic                                   i_op,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_1,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_2
);
        import rv_decode_pkg::*;

        localparam int NUM_REGS = 1 << REG_ADDR_W;

        logic [XLEN-1:0] regs [NUM_REGS];
        logic            wr_en;

        assign wr_en = i_op && (i_w_reg_num != '0);   // writes to x0 dropped.

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en) begin
                        regs[i_w_reg_num] <= i_w_val;
                end
        end

        // reads: x0 first, then bypass from the write port.
        assign o_rs_1 = (i_rs1_num == '0)                      ? '0      :
                        (wr_en && i_rs1_num == i_w_reg_num)    ? i_w_val :
                                                                 regs[i_rs1_num];
        assign o_rs_2 = (i_rs2_num == '0)                      ? '0      :
                        (wr_en && i_rs2_num == i_w_reg_num)    ? i_w_val :
                                                                 regs[i_rs2_num];

endmodule

/* hw/data_hazard_unit.sv */
`timescale 1ns/100ps

module data_hazard_unit (
        input  logic [6:0]                             i_opcode,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_rs1_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_rs2_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_id_ex_rd_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_ex_mem_rd_num,
        output logic                                   o_stall
);
        import rv_decode_pkg::*;

        logic rs1_used;
        logic rs2_used;
        logic rs1_hit;
        logic rs2_hit;

        // which source fields the opcode really reads.
        always_comb begin
                rs1_used = 1'b0;
                rs2_used = 1'b0;
                case (i_opcode)
                        OP_LUI, OP_AUIPC, OP_JAL: ;   // no register sources.
                        OP_JALR, OP_LOAD, OP_IMM: rs1_used = 1'b1;
                        OP_BRANCH, OP_STORE, OP_REG: begin
                                rs1_used = 1'b1;
                                rs2_used = 1'b1;
                        end
                        default: ;   // unknown opcode, never stalls.
                endcase
        end

        // x0 never carries a dependency.
        assign rs1_hit = rs1_used && (i_rs1_num != '0) &&
                         (i_rs1_num == i_id_ex_rd_num || i_rs1_num == i_ex_mem_rd_num);
        assign rs2_hit = rs2_used && (i_rs2_num != '0) &&
                         (i_rs2_num == i_id_ex_rd_num || i_rs2_num == i_ex_mem_rd_num);

        assign o_stall = rs1_hit || rs2_hit;   // no forwarding, so just wait.

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
        input  logic [rv_decode_pkg::XLEN-1:0]  i_pc,
        input  logic [6:0]                      i_opcode,
        input  logic [2:0]                      i_func_3,
        input  logic [11:0]                     i_imm_12_i,
        input  logic [11:0]                     i_imm_12_b,
        input  logic [19:0]                     i_imm_20_j,
        input  logic [rv_decode_pkg::XLEN-1:0]  i_rs_1,
        input  logic [rv_decode_pkg::XLEN-1:0]  i_rs_2,
        output logic                            o_b_taken,
        output logic [rv_decode_pkg::XLEN-1:0]  o_b_pc
);
        import rv_decode_pkg::*;

        logic [XLEN-1:0] off_b;
        logic [XLEN-1:0] off_j;
        logic [XLEN-1:0] off_i;
        logic [XLEN-1:0] jalr_sum;
        logic            cond;

        // sign extend; b and j come in halfword units.
        assign off_b    = {{(XLEN-13){i_imm_12_b[11]}}, i_imm_12_b, 1'b0};
        assign off_j    = {{(XLEN-21){i_imm_20_j[19]}}, i_imm_20_j, 1'b0};
        assign off_i    = {{(XLEN-12){i_imm_12_i[11]}}, i_imm_12_i};
        assign jalr_sum = i_rs_1 + off_i;

        // ******************************
        // branch compare
        // ******************************
        always_comb begin
                case (i_func_3)
                        F3_BEQ:  cond = (i_rs_1 == i_rs_2);
                        F3_BNE:  cond = (i_rs_1 != i_rs_2);
                        F3_BLT:  cond = ($signed(i_rs_1) < $signed(i_rs_2));
                        F3_BGE:  cond = ($signed(i_rs_1) >= $signed(i_rs_2));
                        F3_BLTU: cond = (i_rs_1 < i_rs_2);
                        F3_BGEU: cond = (i_rs_1 >= i_rs_2);
                        default: cond = 1'b0;   // 010 and 011 are not branches.
                endcase
        end

        always_comb begin
                o_b_taken = 1'b0;
                o_b_pc    = '0;
                case (i_opcode)
                        OP_BRANCH: begin
                                o_b_taken = cond;
                                o_b_pc    = i_pc + off_b;   // target even if not taken.
                        end
                        OP_JAL: begin
                                o_b_taken = 1'b1;
                                o_b_pc    = i_pc + off_j;
                        end
                        OP_JALR: begin
                                o_b_taken = 1'b1;
                                o_b_pc    = {jalr_sum[XLEN-1:1], 1'b0};   // lsb cleared.
                        end
                        default: ;
                endcase
        end

endmodule

/* hw/id_ex_register.sv */
`timescale 1ns/100ps

module id_ex_register (
        input  logic                                   i_clk,
        input  logic                                   i_rst,
        input  logic                                   i_stall,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_pc,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_rs_1,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_rs_2,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_rd_num,
        input  logic [6:0]                             i_opcode,
        input  logic [2:0]                             i_func_3,
        input  logic [6:0]                             i_func_7,
        input  logic [11:0]                            i_imm_12_i,
        input  logic [11:0]                            i_imm_12_s,
        input  logic [11:0]                            i_imm_12_b,
        input  logic [19:0]                            i_imm_20_u,
        input  logic [19:0]                            i_imm_20_j,
        input  logic                                   i_b_taken,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_b_pc,
        output logic [rv_decode_pkg::XLEN-1:0]         o_pc,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_1,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_2,
        output logic [rv_decode_pkg::REG_ADDR_W-1:0]   o_rd_num,
        output logic [6:0]                             o_opcode,
        output logic [2:0]                             o_func_3,
        output logic [6:0]                             o_func_7,
        output logic [11:0]                            o_imm_12_i,
        output logic [11:0]                            o_imm_12_s,
        output logic [11:0]                            o_imm_12_b,
        output logic [19:0]                            o_imm_20_u,
        output logic [19:0]                            o_imm_20_j,
        output logic                                   o_b_taken,
        output logic [rv_decode_pkg::XLEN-1:0]         o_b_pc
);

        // an all-zero bundle is a bubble, opcode 0 matches nothing.
        always_ff @(posedge i_clk) begin
                if (i_rst || i_stall) begin
                        o_pc       <= '0;
                        o_rs_1     <= '0;
                        o_rs_2     <= '0;
                        o_rd_num   <= '0;   // no write-back from a bubble.
                        o_opcode   <= '0;
                        o_func_3   <= '0;
                        o_func_7   <= '0;
                        o_imm_12_i <= '0;
                        o_imm_12_s <= '0;
                        o_imm_12_b <= '0;
                        o_imm_20_u <= '0;
                        o_imm_20_j <= '0;
                        o_b_taken  <= 1'b0;   // a bubble never redirects.
                        o_b_pc     <= '0;
                end else begin
                        o_pc       <= i_pc;
                        o_rs_1     <= i_rs_1;
                        o_rs_2     <= i_rs_2;
                        o_rd_num   <= i_rd_num;
                        o_opcode   <= i_opcode;
                        o_func_3   <= i_func_3;
                        o_func_7   <= i_func_7;
                        o_imm_12_i <= i_imm_12_i;
                        o_imm_12_s <= i_imm_12_s;
                        o_imm_12_b <= i_imm_12_b;
                        o_imm_20_u <= i_imm_20_u;
                        o_imm_20_j <= i_imm_20_j;
                        o_b_taken  <= i_b_taken;
                        o_b_pc     <= i_b_pc;
                end
        end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
        input  logic                                   i_clk,
        input  logic                                   i_rst,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_inst,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_pc,
        input  logic                                   i_reg_op,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_w_rd_num,
        input  logic [rv_decode_pkg::XLEN-1:0]         i_w_rd,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_id_ex_rd_num,
        input  logic [rv_decode_pkg::REG_ADDR_W-1:0]   i_ex_mem_rd_num,
        output logic                                   o_stall,
        output logic [rv_decode_pkg::XLEN-1:0]         o_pc,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_1,
        output logic [rv_decode_pkg::XLEN-1:0]         o_rs_2,
        output logic [rv_decode_pkg::REG_ADDR_W-1:0]   o_rd_num,
        output logic [6:0]                             o_opcode,
        output logic [2:0]                             o_func_3,
        output logic [6:0]                             o_func_7,
        output logic [11:0]                            o_imm_12_i,
        output logic [11:0]                            o_imm_12_s,
        output logic [11:0]                            o_imm_12_b,
        output logic [19:0]                            o_imm_20_u,
        output logic [19:0]                            o_imm_20_j,
        output logic                                   o_b_taken,
        output logic [rv_decode_pkg::XLEN-1:0]         o_b_pc
);
        import rv_decode_pkg::*;

        rv_inst_u              inst;
        logic [6:0]            opcode;
        logic [2:0]            func_3;
        logic [6:0]            func_7;
        logic [REG_ADDR_W-1:0] rs1_num;
        logic [REG_ADDR_W-1:0] rs2_num;
        logic [REG_ADDR_W-1:0] rd_num;
        logic [11:0]           imm_12_i;
        logic [11:0]           imm_12_s;
        logic [11:0]           imm_12_b;
        logic [19:0]           imm_20_u;
        logic [19:0]           imm_20_j;
        logic [XLEN-1:0]       rs_1;
        logic [XLEN-1:0]       rs_2;
        logic                  b_taken;
        logic [XLEN-1:0]       b_pc;

        assign inst = i_inst;   // raw word into the format views.

        // ******************************
        // decode and operand read
        // ******************************
        inst_decoder inst_decoder_0 (
                .i_inst     (inst),
                .o_opcode   (opcode),
                .o_func_3   (func_3),
                .o_func_7   (func_7),
                .o_rs1_num  (rs1_num),
                .o_rs2_num  (rs2_num),
                .o_rd_num   (rd_num),
                .o_imm_12_i (imm_12_i),
                .o_imm_12_s (imm_12_s),
                .o_imm_12_b (imm_12_b),
                .o_imm_20_u (imm_20_u),
                .o_imm_20_j (imm_20_j)
        );

        register_file register_file_0 (
                .i_clk       (i_clk),
                .i_rst       (i_rst),
                .i_rs1_num   (rs1_num),
                .i_rs2_num   (rs2_num),
                .i_w_reg_num (i_w_rd_num),
                .i_w_val     (i_w_rd),
                .i_op        (i_reg_op),
                .o_rs_1      (rs_1),
                .o_rs_2      (rs_2)
        );

        // stall goes straight out, fetch holds on it.
        data_hazard_unit data_hazard_unit_0 (
                .i_opcode        (opcode),
                .i_rs1_num       (rs1_num),
                .i_rs2_num       (rs2_num),
                .i_id_ex_rd_num  (i_id_ex_rd_num),
                .i_ex_mem_rd_num (i_ex_mem_rd_num),
                .o_stall         (o_stall)
        );

        branch_unit branch_unit_0 (
                .i_pc       (i_pc),
                .i_opcode   (opcode),
                .i_func_3   (func_3),
                .i_imm_12_i (imm_12_i),
                .i_imm_12_b (imm_12_b),
                .i_imm_20_j (imm_20_j),
                .i_rs_1     (rs_1),
                .i_rs_2     (rs_2),
                .o_b_taken  (b_taken),
                .o_b_pc     (b_pc)
        );

        id_ex_register id_ex_register_0 (
                .i_clk      (i_clk),
                .i_rst      (i_rst),
                .i_stall    (o_stall),   // bubble on hazard.
                .i_pc       (i_pc),
                .i_rs_1     (rs_1),
                .i_rs_2     (rs_2),
                .i_rd_num   (rd_num),
                .i_opcode   (opcode),
                .i_func_3   (func_3),
                .i_func_7   (func_7),
                .i_imm_12_i (imm_12_i),
                .i_imm_12_s (imm_12_s),
                .i_imm_12_b (imm_12_b),
                .i_imm_20_u (imm_20_u),
                .i_imm_20_j (imm_20_j),
                .i_b_taken  (b_taken),
                .i_b_pc     (b_pc),
                .o_pc       (o_pc),
                .o_rs_1     (o_rs_1),
                .o_rs_2     (o_rs_2),
                .o_rd_num   (o_rd_num),
                .o_opcode   (o_opcode),
                .o_func_3   (o_func_3),
                .o_func_7   (o_func_7),
                .o_imm_12_i (o_imm_12_i),
                .o_imm_12_s (o_imm_12_s),
                .o_imm_12_b (o_imm_12_b),
                .o_imm_20_u (o_imm_20_u),
                .o_imm_20_j (o_imm_20_j),
                .o_b_taken  (o_b_taken),
                .o_b_pc     (o_b_pc)
        );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
        output logic o_clk
);

        localparam int HALF_PERIOD = 50;   // 100 ns period.

        initial begin
                o_clk = 1'b0;              // first rising edge at 50 ns.
                forever begin
                        #(HALF_PERIOD) o_clk = ~o_clk;
                end
        end

endmodule

/* tb/tb_decode_stage.sv */
`timescale 1ns/100ps

module tb_decode_stage;

        localparam int CLK_PERIOD = 100;
        localparam int WORDS      = 16;          // words per pattern line.
        localparam int MAX_PATS   = 64;
        localparam logic [31:0] END_MARK = 32'hf;

        // dut inputs.
        logic        clk;
        logic        rst;
        logic [31:0] inst;
        logic [31:0] pc;
        logic        reg_op;
        logic [4:0]  w_rd_num;
        logic [31:0] w_rd;
        logic [4:0]  id_ex_rd;
        logic [4:0]  ex_mem_rd;

        // dut outputs from the id/ex bundle.
        logic        stall;
        logic [31:0] ex_pc;
        logic [31:0] ex_rs_1;
        logic [31:0] ex_rs_2;
        logic [4:0]  ex_rd_num;
        logic [6:0]  ex_opcode;
        logic [2:0]  ex_func_3;
        logic [6:0]  ex_func_7;
        logic [11:0] ex_imm_12_i;
        logic [11:0] ex_imm_12_s;
        logic [11:0] ex_imm_12_b;
        logic [19:0] ex_imm_20_u;
        logic [19:0] ex_imm_20_j;
        logic        ex_b_taken;
        logic [31:0] ex_b_pc;

        logic [31:0] pat_mem [0:WORDS*MAX_PATS-1];
        integer      pat_count;
        integer      error_count;
        integer      seed = 32'h36ff;
        logic [31:0] applied_pc;                 // pc as really driven.

        // expected bundle starts all zero.
        logic [31:0] exp_pc    = '0;
        logic [31:0] exp_inst  = '0;             // source of func and imm fields.
        logic [31:0] exp_rs_1  = '0;
        logic [31:0] exp_rs_2  = '0;
        logic [31:0] exp_rd    = '0;
        logic [31:0] exp_op    = '0;
        logic [31:0] exp_imm_i = '0;
        logic [31:0] exp_taken = '0;
        logic [31:0] exp_b_pc  = '0;

        tb_clock_gen clock_gen_0 (.o_clk(clk));

        decode_stage decode_stage_i (
                .i_clk (clk), .i_rst (rst), .i_inst (inst), .i_pc (pc),
                .i_reg_op (reg_op), .i_w_rd_num (w_rd_num), .i_w_rd (w_rd),
                .i_id_ex_rd_num (id_ex_rd), .i_ex_mem_rd_num (ex_mem_rd),
                .o_stall (stall), .o_pc (ex_pc), .o_rs_1 (ex_rs_1), .o_rs_2 (ex_rs_2),
                .o_rd_num (ex_rd_num), .o_opcode (ex_opcode), .o_func_3 (ex_func_3),
                .o_func_7 (ex_func_7), .o_imm_12_i (ex_imm_12_i),
                .o_imm_12_s (ex_imm_12_s), .o_imm_12_b (ex_imm_12_b),
                .o_imm_20_u (ex_imm_20_u), .o_imm_20_j (ex_imm_20_j),
                .o_b_taken (ex_b_taken), .o_b_pc (ex_b_pc)
        );

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
                if (got !== want) begin
                        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
                        error_count = error_count + 1;
                end
        endtask

        // ******************************
        // pattern handling
        // ******************************
        task automatic apply_pattern(input int idx);
                int          b;
                logic [31:0] rnd;
                b = idx * WORDS;
                applied_pc = pat_mem[b+5];
                if (pat_mem[b] == 32'h1) begin   // upper pc half is free.
                        rnd = $random(seed);
                        applied_pc = {rnd[15:0], applied_pc[15:0]};
                end
                reg_op    <= pat_mem[b+1][0];
                w_rd_num  <= pat_mem[b+2][4:0];
                w_rd      <= pat_mem[b+3];
                inst      <= pat_mem[b+4];
                pc        <= applied_pc;
                id_ex_rd  <= pat_mem[b+6][4:0];
                ex_mem_rd <= pat_mem[b+7][4:0];
        endtask

        task automatic load_expected(input int idx);
                int   b;
                logic bubble;
                b = idx * WORDS;
                bubble    = pat_mem[b+8][0];     // a stall means a zero bundle.
                exp_taken = pat_mem[b+9];
                exp_rs_1  = pat_mem[b+11];
                exp_rs_2  = pat_mem[b+12];
                exp_rd    = pat_mem[b+13];
                exp_op    = pat_mem[b+14];
                exp_imm_i = pat_mem[b+15];
                exp_pc    = bubble ? 32'h0 : applied_pc;
                exp_inst  = bubble ? 32'h0 : pat_mem[b+4];
                exp_b_pc  = pat_mem[b+10];
                if (pat_mem[b] == 32'h1 && !bubble) begin
                        exp_b_pc = applied_pc + pat_mem[b+10];   // column is an offset.
                end
        endtask

        task automatic check_bundle;
                check_value("o_pc", ex_pc, exp_pc);
                check_value("o_rs_1", ex_rs_1, exp_rs_1);
                check_value("o_rs_2", ex_rs_2, exp_rs_2);
                check_value("o_rd_num", 32'(ex_rd_num), exp_rd);
                check_value("o_opcode", 32'(ex_opcode), exp_op);
                check_value("o_imm_12_i", 32'(ex_imm_12_i), exp_imm_i);
                check_value("o_b_taken", 32'(ex_b_taken), exp_taken);
                check_value("o_b_pc", ex_b_pc, exp_b_pc);
                // reference bit order of the base formats.
                check_value("o_func_3", 32'(ex_func_3), 32'(exp_inst[14:12]));
                check_value("o_func_7", 32'(ex_func_7), 32'(exp_inst[31:25]));
                check_value("o_imm_12_s", 32'(ex_imm_12_s),
                            32'({exp_inst[31:25], exp_inst[11:7]}));
                check_value("o_imm_12_b", 32'(ex_imm_12_b),
                            32'({exp_inst[31], exp_inst[7], exp_inst[30:25], exp_inst[11:8]}));
                check_value("o_imm_20_u", 32'(ex_imm_20_u), 32'(exp_inst[31:12]));
                check_value("o_imm_20_j", 32'(ex_imm_20_j),
                            32'({exp_inst[31], exp_inst[19:12], exp_inst[20], exp_inst[30:21]}));
        endtask

        // ******************************
        // main sequence
        // ******************************
        initial begin
                rst         = 1'b1;
                inst        = 32'h001000ef;      // a live jal sits on the inputs in reset.
                pc          = 32'h00000100;
                reg_op      = 1'b0;
                w_rd_num    = '0;
                w_rd        = '0;
                id_ex_rd    = '0;
                ex_mem_rd   = '0;
                error_count = 0;
                pat_count   = -1;
                $readmemh("tb/decode_patterns.mem", pat_mem);
                for (int i = 0; i < MAX_PATS; i++) begin
                        if (pat_count < 0 && pat_mem[i * WORDS] == END_MARK) begin
                                pat_count = i;
                        end
                end
                if (pat_count < 0) begin
                        $display("Pattern table has no end marker, so no pattern was run.");
                        error_count = error_count + 1;
                        pat_count = 0;
                end

                repeat (10) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);                  // everything still cleared.
                check_value("o_stall", 32'(stall), 32'h0);
                check_bundle();

                // one pattern per cycle and its bundle one cycle later.
                for (int i = 0; i <= pat_count; i++) begin
                        @(posedge clk);
                        if (i < pat_count) begin
                                apply_pattern(i);
                        end
                        @(negedge clk);
                        if (i > 0) begin
                                check_bundle();
                        end
                        if (i < pat_count) begin
                                check_value("o_stall", 32'(stall), pat_mem[i*WORDS+8]);
                                load_expected(i);
                        end
                end

                $display("%0d errors over %0d patterns.", error_count, pat_count);
                if (error_count == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

        // watchdog sized by pattern count plus slack for reset.
        initial begin
                #1;
                #((pat_count + 20) * CLK_PERIOD);
                $display("Simulation hung: the watchdog ran out before the patterns finished.");
                $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule

/* tb/decode_patterns.mem */
// mode reg_op w_rd_num w_rd inst pc id_ex_rd ex_mem_rd, then expected: stall b_taken b_pc
// rs_1 rs_2 rd_num opcode imm_12_i. mode 1 randomizes pc[31:16], b_pc is then an offset.
// writes with write-through reads, x0 write dropped
0 1 01 00000005 00108333 00000100 00 00 0 0 00000000 00000005 00000005 06 33 001
0 1 02 fffffffb fff10393 00000104 00 00 0 0 00000000 fffffffb 00000000 07 13 fff
0 1 00 deadbeef 00100433 00000108 00 00 0 0 00000000 00000000 00000005 08 33 001
0 1 03 00000005 403084b3 0000010c 00 00 0 0 00000000 00000005 00000005 09 33 403
0 1 04 80000000 12345537 00000110 03 00 0 0 00000000 00000000 00000005 0a 37 123
0 1 05 00001000 fffff597 00000114 00 00 0 0 00000000 00000000 00000000 0b 17 fff
0 0 00 00000000 0022a423 00000118 00 00 0 0 00000000 00001000 fffffffb 08 23 002
0 0 00 00000000 ffc22603 0000011c 00 00 0 0 00000000 80000000 00000000 0c 03 ffc
// branches, each condition taken and not taken
1 0 00 00000000 00308863 00000120 00 00 0 1 00000010 00000005 00000005 10 63 003
1 0 00 00000000 fe309ce3 00000124 00 00 0 0 fffffff8 00000005 00000005 19 63 fe3
1 0 00 00000000 00114863 00000128 00 00 0 1 00000010 fffffffb 00000005 10 63 001
1 0 00 00000000 00116863 0000012c 00 00 0 0 00000010 fffffffb 00000005 10 63 001
1 0 00 00000000 fe30dce3 00000130 00 00 0 1 fffffff8 00000005 00000005 19 63 fe3
1 0 00 00000000 00115863 00000134 00 00 0 0 00000010 fffffffb 00000005 10 63 001
1 0 00 00000000 fe127ce3 00000138 00 00 0 1 fffffff8 80000000 00000005 19 63 fe1
1 0 00 00000000 00124863 0000013c 00 00 0 1 00000010 80000000 00000005 10 63 001
1 0 00 00000000 fe40ece3 00000140 00 00 0 1 fffffff8 00000005 80000000 19 63 fe4
1 0 00 00000000 00208863 00000144 00 00 0 0 00000010 00000005 fffffffb 10 63 002
1 0 00 00000000 fe209ce3 00000148 00 00 0 1 fffffff8 00000005 fffffffb 19 63 fe2
1 0 00 00000000 0040f863 0000014c 00 00 0 0 00000010 00000005 80000000 10 63 004
1 0 00 00000000 0020c863 00000150 00 00 0 0 00000010 00000005 fffffffb 10 63 002
// jal and jalr
1 0 00 00000000 001000ef 00000154 00 00 0 1 00000800 00000000 00000005 01 6f 001
1 0 00 00000000 ffdff06f 00000158 00 00 0 1 fffffffc 00000000 00000000 00 6f ffd
0 0 00 00000000 003280e7 0000015c 00 00 0 1 00001002 00001000 00000005 01 67 003
0 0 00 00000000 ffa10067 00000160 00 00 0 1 fffffff4 fffffffb 00000000 00 67 ffa
// hazards, bubbles and sources that must not stall
0 0 00 00000000 00108333 00000164 01 00 1 0 00000000 00000000 00000000 00 00 000
0 0 00 00000000 00108333 00000164 00 00 0 0 00000000 00000005 00000005 06 33 001
0 0 00 00000000 0022a423 00000168 00 02 1 0 00000000 00000000 00000000 00 00 000
0 0 00 00000000 fff10393 0000016c 00 1f 0 0 00000000 fffffffb 00000000 07 13 fff
0 0 00 00000000 00100433 00000170 00 08 0 0 00000000 00000000 00000005 08 33 001
0 0 00 00000000 00308863 00000174 03 00 1 0 00000000 00000000 00000000 00 00 000
0 0 00 00000000 003280e7 00000178 00 05 1 0 00000000 00000000 00000000 00 00 000
f

/* verilog.f */
hw/rv_decode_pkg.sv
hw/inst_decoder.sv
hw/register_file.sv
hw/data_hazard_unit.sv
hw/branch_unit.sv
hw/id_ex_register.sv
hw/decode_stage.sv
tb/tb_clock_gen.sv
tb/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# builds the decode stage testbench with verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_decode_stage -f verilog.f
out=$(./obj_dir/Vtb_decode_stage)
echo "$out"

# the exit status of grep decides pass or fail.
echo "$out" | grep -qx "TEST RESULT: PASS"
